//--- compile.f
+incdir+test
rtl/board_pkg.sv
rtl/io_decode.sv
rtl/bus_arbiter.sv
rtl/tone_timer.sv
rtl/check_nmi.sv
rtl/board_regs.sv
rtl/system_board.sv
test/tb_system_board.sv

//--- rtl/board_pkg.sv
//******************************
// system board package
// widths, i/o map and the bus, select and port types
//******************************
package board_pkg;

   // widths
   localparam int IO_ADDR_W  = 10;
   localparam int DATA_W     = 8;
   localparam int PAGE_W     = 4;
   localparam int DMA_CH     = 4;
   localparam int PAGE_IDX_W = $clog2(DMA_CH);
   localparam int TIMER_W    = 16;
   localparam int PCLK_DIV   = 4;            // system clocks per timer tick
   localparam int PCLK_DIV_W = $clog2(PCLK_DIV);
   localparam logic [PCLK_DIV_W-1:0] PRE_LAST = PCLK_DIV_W'(PCLK_DIV - 1);

   // i/o map, block code is a7..a5
   localparam logic [2:0] BLK_TIMER = 3'd2;  // 0x40
   localparam logic [2:0] BLK_PPI   = 3'd3;  // 0x60
   localparam logic [2:0] BLK_PAGE  = 3'd4;  // 0x80
   localparam logic [2:0] BLK_NMI   = 3'd5;  // 0xa0

   localparam logic [1:0] OFS_TIMER2 = 2'd2;
   localparam logic [1:0] OFS_PORT_B = 2'd1;
   localparam logic [1:0] OFS_PORT_C = 2'd2;

   localparam logic [DATA_W-1:0] IDLE_READ = 8'hFF;  // floating bus

   typedef struct packed {
      logic                 cyc;
      logic                 stb;
      logic                 we;
      logic [IO_ADDR_W-1:0] adr;
      logic [DATA_W-1:0]    dat;
   } wb_req_t;

   typedef struct packed {
      logic              ack;
      logic [DATA_W-1:0] dat;
   } wb_rsp_t;

   // one-hot or zero
   typedef struct packed {
      logic timer;
      logic ppi;
      logic page;
      logic nmi;
   } io_sel_t;

   typedef struct packed {
      logic holda;
      logic aen;
      logic dma_aen;
   } dma_ctrl_t;

   // port b of the 8255, seen as a bus byte or as control bits
   typedef union packed {
      logic [DATA_W-1:0] raw;
      struct packed {
         logic [1:0] spare_hi;
         logic       io_chk_off;      // high disables the i/o check
         logic       parity_chk_off;  // high disables the parity check
         logic       spare_3;         // old cassette motor bit
         logic       spare_2;
         logic       spkr_data;
         logic       tim2_gate;
      } f;
   } port_b_u;

   typedef struct packed {
      logic       parity_chk;
      logic       io_chk;
      logic       tim2_out;
      logic [4:0] rsvd;
   } port_c_t;

endpackage

//--- rtl/board_regs.sv
//******************************
// wishbone slave for the i/o registers
// port b/c, nmi mask, dma pages, timer reload
//******************************
`timescale 1ns/1ps

module board_regs (
   input  logic                                clk,
   input  logic                                reset_n,
   input  board_pkg::wb_req_t                  wb_req_i,
   output board_pkg::wb_rsp_t                  wb_rsp_o,
   input  board_pkg::io_sel_t                  sel_i,
   input  board_pkg::dma_ctrl_t                dma_i,
   input  logic [board_pkg::PAGE_IDX_W-1:0]    dma_chan_i,
   input  logic                                tim2_out_i,
   input  logic                                parity_chk_i,
   input  logic                                io_chk_i,
   output board_pkg::port_b_u                  port_b_o,
   output logic [board_pkg::TIMER_W-1:0]       reload_o,
   output logic                                reload_we_o,
   output logic                                nmi_allow_o,
   output logic [board_pkg::PAGE_W-1:0]        page_addr_o
);

   logic                               ack_q;
   logic [board_pkg::DATA_W-1:0]       rd_q;
   logic [board_pkg::DATA_W-1:0]       rd_data;
   logic [board_pkg::PAGE_IDX_W-1:0]   ofs;
   logic                               access;
   logic                               wr;
   logic                               wr_port_b;
   logic                               wr_page;
   logic                               wr_nmi;
   logic                               wr_timer;
   logic                               hi_ptr;  // next timer byte is the high one
   logic [board_pkg::DATA_W-1:0]       lo_byte;
   logic [board_pkg::PAGE_W-1:0]       page_q [board_pkg::DMA_CH];
   board_pkg::port_c_t                 port_c;

   assign ofs    = wb_req_i.adr[1:0];
   assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;  // ack rises next edge
   assign wr     = access && wb_req_i.we;

   assign wr_port_b = wr && sel_i.ppi && (ofs == board_pkg::OFS_PORT_B);
   assign wr_page   = wr && sel_i.page;
   assign wr_nmi    = wr && sel_i.nmi;
   assign wr_timer  = wr && sel_i.timer && (ofs == board_pkg::OFS_TIMER2);

   assign port_c = '{
      parity_chk: parity_chk_i,
      io_chk:     io_chk_i,
      tim2_out:   tim2_out_i,
      rsvd:       '0
   };

   always_comb begin
      rd_data = board_pkg::IDLE_READ;
      if (sel_i.ppi && (ofs == board_pkg::OFS_PORT_B)) begin
         rd_data = port_b_o.raw;
      end else if (sel_i.ppi && (ofs == board_pkg::OFS_PORT_C)) begin
         rd_data = port_c;
      end else if (sel_i.page) begin
         rd_data = {{(board_pkg::DATA_W - board_pkg::PAGE_W){1'b0}}, page_q[ofs]};
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         ack_q       <= 1'b0;
         rd_q        <= '0;
         port_b_o    <= '0;
         page_q      <= '{default: '0};
         nmi_allow_o <= 1'b0;
         hi_ptr      <= 1'b0;
         lo_byte     <= '0;
         reload_o    <= '0;
         reload_we_o <= 1'b0;
      end else begin
         ack_q       <= access;
         reload_we_o <= 1'b0;
         if (access) begin
            rd_q <= rd_data;
         end
         if (wr_port_b) begin
            port_b_o.raw <= wb_req_i.dat;
         end
         if (wr_page) begin
            page_q[ofs] <= wb_req_i.dat[board_pkg::PAGE_W-1:0];
         end
         if (wr_nmi) begin
            nmi_allow_o <= wb_req_i.dat[7];
         end
         if (wr_timer) begin
            hi_ptr <= !hi_ptr;
            if (hi_ptr) begin
               reload_o    <= {wb_req_i.dat, lo_byte};
               reload_we_o <= 1'b1;  // restarts the timer
            end else begin
               lo_byte <= wb_req_i.dat;
            end
         end
      end
   end

   assign wb_rsp_o = '{ack: ack_q, dat: rd_q};

   // 74LS670 read side drives a19..a16 during the dma cycle
   assign page_addr_o = dma_i.dma_aen ? page_q[dma_chan_i] : '0;

endmodule

//--- rtl/bus_arbiter.sv
//******************************
// hold/acknowledge sequencer
// holda, then aen, then dma_aen
//******************************
`timescale 1ns/1ps

module bus_arbiter (
   input  logic                 clk,
   input  logic                 reset_n,
   input  logic                 hrq_i,
   input  logic                 cpu_idle_i,
   output board_pkg::dma_ctrl_t dma_o
);

   typedef enum logic [2:0] {
      IDLE,
      SYNC,
      HOLD,
      ADDR_EN,
      DMA
   } arb_state_e;

   arb_state_e state;
   arb_state_e state_nxt;

   always_comb begin
      state_nxt = state;
      if (!hrq_i) begin
         state_nxt = IDLE;  // request gone, give the bus back now
      end else begin
         case (state)
            IDLE: begin
               if (cpu_idle_i) begin
                  state_nxt = SYNC;
               end
            end
            SYNC:    state_nxt = HOLD;     // idle sample taken
            HOLD:    state_nxt = ADDR_EN;
            ADDR_EN: state_nxt = DMA;
            DMA:     state_nxt = DMA;
            default: state_nxt = IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // outputs decoded from the state register
   always_comb begin
      dma_o.holda   = (state == HOLD) || (state == ADDR_EN) || (state == DMA);
      dma_o.aen     = (state == ADDR_EN) || (state == DMA);
      dma_o.dma_aen = (state == DMA);
   end

endmodule

//--- rtl/check_nmi.sv
//******************************
// parity and i/o channel check latches, masked nmi
//******************************
`timescale 1ns/1ps

module check_nmi (
   input  logic               clk,
   input  logic               reset_n,
   input  logic               parity_err_i,
   input  logic               io_ch_ck_n_i,
   input  board_pkg::port_b_u port_b_i,
   input  logic               nmi_allow_i,
   output logic               parity_chk_o,
   output logic               io_chk_o,
   output logic               nmi_o
);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         parity_chk_o <= 1'b0;
         io_chk_o     <= 1'b0;
         nmi_o        <= 1'b0;
      end else begin
         if (port_b_i.f.parity_chk_off) begin
            parity_chk_o <= 1'b0;  // held clear while disabled
         end else if (parity_err_i) begin
            parity_chk_o <= 1'b1;
         end

         if (port_b_i.f.io_chk_off) begin
            io_chk_o <= 1'b0;
         end else if (!io_ch_ck_n_i) begin
            io_chk_o <= 1'b1;
         end

         nmi_o <= nmi_allow_i && (parity_chk_o || io_chk_o);
      end
   end

endmodule

//--- rtl/io_decode.sv
//******************************
// i/o block decode
// 74LS138 style select on a9..a5
//******************************
`timescale 1ns/1ps

module io_decode (
   input  logic [board_pkg::IO_ADDR_W-1:0] adr_i,
   input  board_pkg::dma_ctrl_t            dma_i,
   output board_pkg::io_sel_t              sel_o
);

   logic [2:0] blk;
   logic       enable;

   assign blk = adr_i[7:5];

   // a9 and a8 low, and the cpu owns the bus
   assign enable = (adr_i[9:8] == 2'b00) && !dma_i.aen;

   always_comb begin
      sel_o = '0;
      if (enable) begin
         case (blk)
            board_pkg::BLK_TIMER: sel_o.timer = 1'b1;
            board_pkg::BLK_PPI:   sel_o.ppi   = 1'b1;
            board_pkg::BLK_PAGE:  sel_o.page  = 1'b1;
            board_pkg::BLK_NMI:   sel_o.nmi   = 1'b1;
            default: begin
               sel_o = '0;  // dma, pic and unused blocks
            end
         endcase
      end
   end

endmodule

//--- rtl/system_board.sv
//******************************
// system board i/o glue, top level
//******************************
`timescale 1ns/1ps

module system_board (
   input  logic                              clk,
   input  logic                              reset_n,
   input  board_pkg::wb_req_t                wb_req_i,
   output board_pkg::wb_rsp_t                wb_rsp_o,
   input  logic                              hrq_i,
   input  logic                              cpu_idle_i,
   input  logic [board_pkg::PAGE_IDX_W-1:0]  dma_chan_i,
   input  logic                              parity_err_i,
   input  logic                              io_ch_ck_n_i,
   output board_pkg::dma_ctrl_t              dma_o,
   output logic [board_pkg::PAGE_W-1:0]      page_addr_o,
   output logic                              spkr_o,
   output logic                              nmi_o
);

   board_pkg::io_sel_t              sel;
   board_pkg::port_b_u              port_b;
   logic [board_pkg::TIMER_W-1:0]   reload;
   logic                            reload_we;
   logic                            nmi_allow;
   logic                            tim2_out;
   logic                            parity_chk;
   logic                            io_chk;

   bus_arbiter u_arbiter (
      .clk        (clk),
      .reset_n    (reset_n),
      .hrq_i      (hrq_i),
      .cpu_idle_i (cpu_idle_i),
      .dma_o      (dma_o)
   );

   io_decode u_decode (
      .adr_i (wb_req_i.adr),
      .dma_i (dma_o),
      .sel_o (sel)
   );

   board_regs u_regs (
      .clk          (clk),
      .reset_n      (reset_n),
      .wb_req_i     (wb_req_i),
      .wb_rsp_o     (wb_rsp_o),
      .sel_i        (sel),
      .dma_i        (dma_o),
      .dma_chan_i   (dma_chan_i),
      .tim2_out_i   (tim2_out),
      .parity_chk_i (parity_chk),
      .io_chk_i     (io_chk),
      .port_b_o     (port_b),
      .reload_o     (reload),
      .reload_we_o  (reload_we),
      .nmi_allow_o  (nmi_allow),
      .page_addr_o  (page_addr_o)
   );

   tone_timer u_timer (
      .clk         (clk),
      .reset_n     (reset_n),
      .reload_i    (reload),
      .reload_we_i (reload_we),
      .port_b_i    (port_b),
      .tim2_out_o  (tim2_out),
      .spkr_o      (spkr_o)
   );

   check_nmi u_check (
      .clk          (clk),
      .reset_n      (reset_n),
      .parity_err_i (parity_err_i),
      .io_ch_ck_n_i (io_ch_ck_n_i),
      .port_b_i     (port_b),
      .nmi_allow_i  (nmi_allow),
      .parity_chk_o (parity_chk),
      .io_chk_o     (io_chk),
      .nmi_o        (nmi_o)
   );

endmodule

//--- rtl/tone_timer.sv
//******************************
// speaker tone timer
// pclk prescaler and 8253 ch2 style square wave
//******************************
`timescale 1ns/1ps

module tone_timer (
   input  logic                           clk,
   input  logic                           reset_n,
   input  logic [board_pkg::TIMER_W-1:0]  reload_i,
   input  logic                           reload_we_i,
   input  board_pkg::port_b_u             port_b_i,
   output logic                           tim2_out_o,
   output logic                           spkr_o
);

   logic [board_pkg::PCLK_DIV_W-1:0] pre_cnt;
   logic                             tick;
   logic [board_pkg::TIMER_W-1:0]    count;
   logic                             hold_load;  // gate low or no count written

   assign tick      = (pre_cnt == board_pkg::PRE_LAST);
   assign hold_load = !port_b_i.f.tim2_gate || (reload_i == '0);

   // free running from reset, reload writes leave it alone
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         pre_cnt <= '0;
      end else if (tick) begin
         pre_cnt <= '0;
      end else begin
         pre_cnt <= pre_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         count      <= '0;
         tim2_out_o <= 1'b1;
      end else if (hold_load) begin
         count      <= reload_i;
         tim2_out_o <= 1'b1;
      end else if (reload_we_i) begin
         count <= reload_i;  // new count, restart
      end else if (tick) begin
         if (count[board_pkg::TIMER_W-1:1] == '0) begin
            // would hit zero, half period done
            tim2_out_o <= !tim2_out_o;
            count      <= reload_i;
         end else begin
            count <= count - 1'b1;
         end
      end
   end

   // speaker data masks the tone
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         spkr_o <= 1'b0;
      end else begin
         spkr_o <= tim2_out_o && port_b_i.f.spkr_data;
      end
   end

endmodule

//--- test/tb_tasks.svh
//******************************
// bus tasks, checks and directed tests
//******************************

task automatic fail_run(input string why);
   $display("ERROR: %s", why);
   $display("** FAIL **");
   $fatal(1, "run stopped");
endtask

task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                        input string what);
   if (actual !== expected) begin
      $display("MISMATCH at %0d ns: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("** FAIL **");
      $fatal(1, "check failed");
   end
endtask

// 8-bit fibonacci lfsr with taps 8 6 5 4
function automatic logic [15:0] lfsr_take(input int nbits);
   logic [15:0] val;
   logic        fb;
   int          i;
   val = '0;
   for (i = 0; i < nbits; i++) begin
      fb     = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
      lfsr_q = {lfsr_q[6:0], fb};
      val    = {val[14:0], fb};
   end
   return val;
endfunction

// true when one of the first upto page values already equals val
function automatic logic page_value_taken(input logic [3:0] val, input int upto);
   logic hit;
   int   j;
   hit = 1'b0;
   for (j = 0; j < upto; j++) begin
      if (page_val[j] == val) begin
         hit = 1'b1;
      end
   end
   return hit;
endfunction

task automatic next_cycle();
   @(posedge clk);
   #DRIVE_DLY;
endtask

task automatic wait_cycles(input int n);
   repeat (n) next_cycle();
endtask

// one classic cycle held until ack and then stb low for a cycle
task automatic wb_access(input logic we, input logic [9:0] adr,
                         input logic [7:0] wdat, output logic [7:0] rdat);
   int waited;
   waited     = 0;
   wb_req.cyc = 1'b1;
   wb_req.stb = 1'b1;
   wb_req.we  = we;
   wb_req.adr = adr;
   wb_req.dat = wdat;
   next_cycle();
   while (!wb_rsp.ack && waited < ACK_LIMIT) begin
      next_cycle();
      waited++;
   end
   if (!wb_rsp.ack) begin
      fail_run("no ack from the bus slave");
   end else begin
      rdat       = wb_rsp.dat;
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      wb_req.we  = 1'b0;
      next_cycle();
   end
endtask

task automatic wb_write(input logic [9:0] adr, input logic [7:0] data);
   logic [7:0] unused;
   wb_access(1'b1, adr, data, unused);
endtask

task automatic wb_read(input logic [9:0] adr, output logic [7:0] data);
   wb_access(1'b0, adr, 8'h00, data);
endtask

task automatic wait_spkr_toggle(input int limit, output int unsigned at_cycle);
   logic prev;
   int   n;
   prev = spkr_o;
   n    = 0;
   while (spkr_o == prev && n < limit) begin
      next_cycle();
      n++;
   end
   if (spkr_o == prev) begin
      fail_run("speaker output did not toggle");
   end else begin
      at_cycle = cycle_no;
   end
endtask

task automatic test_reset_state();
   logic [7:0] rdat;
   check_eq(dma_o, 3'b000, "dma controls after reset");
   check_eq(spkr_o, 1'b0, "spkr_o after reset");
   check_eq(nmi_o, 1'b0, "nmi_o after reset");
   check_eq(page_addr_o, 4'h0, "page_addr_o after reset");
   wb_read(PORT_B_ADR, rdat);
   check_eq(rdat, 8'h00, "port b after reset");
   wb_read(PORT_C_ADR, rdat);
   check_eq(rdat, 8'h20, "port c after reset");  // gate low keeps out2 high
endtask

task automatic test_readback();
   logic [7:0] rdat;
   int         c;
   port_b_val = 8'(lfsr_take(8));
   wb_write(PORT_B_ADR, port_b_val);
   wb_read(PORT_B_ADR, rdat);
   check_eq(rdat, port_b_val, "port b readback");
   for (c = 0; c < 4; c++) begin
      page_val[c] = 4'(lfsr_take(4));
      while (page_value_taken(page_val[c], c)) begin
         page_val[c] = 4'(lfsr_take(4));  // each register gets its own value
      end
      wb_write(10'(PAGE_ADR + c), {4'h0, page_val[c]});
   end
   for (c = 0; c < 4; c++) begin
      wb_read(10'(PAGE_ADR + c), rdat);
      check_eq(rdat, {4'h0, page_val[c]}, $sformatf("page register %0d readback", c));
   end
   wb_read(10'h3F0, rdat);
   check_eq(rdat, 8'hFF, "unmapped read at 0x3f0");
   wb_read(10'h020, rdat);
   check_eq(rdat, 8'hFF, "unmapped read at 0x020");
endtask

task automatic test_arbitration();
   logic [7:0] rdat;
   int         c;
   cpu_idle_i = 1'b1;
   hrq_i      = 1'b1;
   next_cycle();                   // edge k samples both high
   check_eq(dma_o, 3'b000, "dma controls after edge k");
   next_cycle();
   check_eq(dma_o, 3'b100, "holda after edge k+1");
   cpu_idle_i = 1'b0;              // ignored once started
   next_cycle();
   check_eq(dma_o, 3'b110, "aen after edge k+2");
   next_cycle();
   check_eq(dma_o, 3'b111, "dma_aen after edge k+3");
   for (c = 0; c < 4; c++) begin
      dma_chan_i = 2'(c);
      #1;
      check_eq(page_addr_o, page_val[c], $sformatf("page address for channel %0d", c));
   end
   wb_write(PORT_B_ADR, ~port_b_val);
   wb_read(PORT_B_ADR, rdat);
   check_eq(rdat, 8'hFF, "port b read during dma");
   check_eq(dma_o, 3'b111, "dma controls held during bus cycles");
   hrq_i = 1'b0;
   next_cycle();
   check_eq(dma_o, 3'b000, "dma controls after hrq drop");
   check_eq(page_addr_o, 4'h0, "page address after release");
   wb_read(PORT_B_ADR, rdat);
   check_eq(rdat, port_b_val, "port b unchanged by dma write");
endtask

task automatic test_tone();
   logic [15:0]  n_reload;
   int unsigned  t0;
   int unsigned  t1;
   int unsigned  t2;
   int unsigned  t3;
   int           half;
   int           i;
   n_reload = 16'(2 + (lfsr_take(5) % 19));
   half     = n_reload * board_pkg::PCLK_DIV;
   wb_write(PORT_B_ADR, 8'h00);
   wb_write(TIMER2_ADR, n_reload[7:0]);
   wb_write(TIMER2_ADR, n_reload[15:8]);
   wb_write(PORT_B_ADR, 8'h03);    // gate and speaker data
   wait_spkr_toggle(2 * half + 8, t0);  // first half period is not aligned
   wait_spkr_toggle(2 * half + 8, t1);
   wait_spkr_toggle(2 * half + 8, t2);
   wait_spkr_toggle(2 * half + 8, t3);
   check_eq(t2 - t1, half, "tone half period");
   check_eq(t3 - t2, half, "next tone half period");
   wb_write(PORT_B_ADR, 8'h01);    // speaker data off
   next_cycle();
   for (i = 0; i < 2 * half + 2; i++) begin
      check_eq(spkr_o, 1'b0, "spkr_o with speaker data cleared");
      next_cycle();
   end
   wb_write(PORT_B_ADR, 8'h00);
endtask

task automatic nmi_case(input logic use_io);
   logic [7:0] off_bit;
   logic [7:0] chk_bit;
   logic [7:0] rdat;
   off_bit = use_io ? 8'h20 : 8'h10;
   chk_bit = use_io ? 8'h40 : 8'h80;
   wb_write(PORT_B_ADR, 8'h00);
   wb_write(NMI_ADR, 8'h80);
   wait_cycles(2);
   check_eq(nmi_o, 1'b0, "nmi before the check event");
   if (use_io) begin
      io_ch_ck_n_i = 1'b0;
   end else begin
      parity_err_i = 1'b1;
   end
   next_cycle();
   io_ch_ck_n_i = 1'b1;
   parity_err_i = 1'b0;
   wait_cycles(2);
   check_eq(nmi_o, 1'b1, "nmi after the check event");
   wb_read(PORT_C_ADR, rdat);
   check_eq(rdat, 8'h20 | chk_bit, "port c with check latch set");
   wb_write(NMI_ADR, 8'h00);
   wait_cycles(2);
   check_eq(nmi_o, 1'b0, "nmi with the mask cleared");
   wb_write(NMI_ADR, 8'h80);
   wait_cycles(2);
   check_eq(nmi_o, 1'b1, "nmi with the mask set again");
   wb_write(PORT_B_ADR, off_bit);  // check disabled clears the latch
   wait_cycles(2);
   check_eq(nmi_o, 1'b0, "nmi after the check is disabled");
   wb_read(PORT_C_ADR, rdat);
   check_eq(rdat, 8'h20, "port c after the latch is cleared");
   wb_write(PORT_B_ADR, 8'h00);
   wait_cycles(2);
   check_eq(nmi_o, 1'b0, "nmi after the check is enabled again");
   wb_write(NMI_ADR, 8'h00);
endtask

task automatic test_nmi();
   nmi_case(1'b0);  // parity
   nmi_case(1'b1);  // i/o channel check
endtask

//--- test/tb_system_board.sv
//******************************
// testbench for the system board i/o glue
//******************************
`timescale 1ns/1ps

module tb_system_board;

   localparam int CLK_PERIOD   = 40;
   localparam int DRIVE_DLY    = 2;    // inputs change this long after the edge
   localparam int RESET_CYCLES = 4;
   localparam int ACK_LIMIT    = 8;

   // i/o addresses used by the tests
   localparam logic [9:0] TIMER2_ADR = 10'h042;
   localparam logic [9:0] PORT_B_ADR = 10'h061;
   localparam logic [9:0] PORT_C_ADR = 10'h062;
   localparam logic [9:0] PAGE_ADR   = 10'h080;
   localparam logic [9:0] NMI_ADR    = 10'h0A0;

   // longest tone half period, reload 20
   localparam int HALF_MAX = 20 * board_pkg::PCLK_DIV;

   // rough length of each test in clocks
   localparam int LEN_RESET = RESET_CYCLES + 12;
   localparam int LEN_READBACK = 60;
   localparam int LEN_ARB = 50;
   localparam int LEN_TONE = 5 * HALF_MAX + 40;
   localparam int LEN_NMI = 140;
   localparam int MARGIN = 4 * HALF_MAX;  // two full tone periods
   localparam int WATCHDOG_CYCLES = LEN_RESET + LEN_READBACK + LEN_ARB + LEN_TONE
                                    + LEN_NMI + MARGIN;

   logic                     clk;
   logic                     reset_n;
   board_pkg::wb_req_t       wb_req;
   board_pkg::wb_rsp_t       wb_rsp;
   logic                     hrq_i;
   logic                     cpu_idle_i;
   logic [1:0]               dma_chan_i;
   logic                     parity_err_i;
   logic                     io_ch_ck_n_i;
   board_pkg::dma_ctrl_t     dma_o;
   logic [3:0]               page_addr_o;
   logic                     spkr_o;
   logic                     nmi_o;

   int unsigned              cycle_no = 0;
   logic [7:0]               lfsr_q = 8'd81;
   logic [7:0]               port_b_val;
   logic [3:0]               page_val [4];

   system_board DUT (
      .clk          (clk),
      .reset_n      (reset_n),
      .wb_req_i     (wb_req),
      .wb_rsp_o     (wb_rsp),
      .hrq_i        (hrq_i),
      .cpu_idle_i   (cpu_idle_i),
      .dma_chan_i   (dma_chan_i),
      .parity_err_i (parity_err_i),
      .io_ch_ck_n_i (io_ch_ck_n_i),
      .dma_o        (dma_o),
      .page_addr_o  (page_addr_o),
      .spkr_o       (spkr_o),
      .nmi_o        (nmi_o)
   );

   `include "tb_tasks.svh"

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) cycle_no <= cycle_no + 1;  // clock count for tone timing

   // watchdog
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("ERROR: watchdog expired, the test sequence did not finish in time");
      $display("** FAIL **");
      $fatal(1, "watchdog timeout");
   end

   initial begin
      reset_n      = 1'b0;
      wb_req       = '0;
      hrq_i        = 1'b0;
      cpu_idle_i   = 1'b0;
      dma_chan_i   = 2'd0;
      parity_err_i = 1'b0;
      io_ch_ck_n_i = 1'b1;
      port_b_val   = 8'h00;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DLY reset_n = 1'b1;

      test_reset_state();
      test_readback();
      test_arbitration();
      test_tone();
      test_nmi();

      $display("** PASS **");
      $finish;
   end

endmodule
